// File: Makefile
# Verilator build and run for the LSU subsystem

VERILATOR ?= verilator
TOP       ?= tb_lsu_subsys
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sources.f
src/isa_pkg.sv
src/ctl_pkg.sv
src/lsu_align.sv
src/lsu_ctrl.sv
src/wait_timer.sv
src/data_ram.sv
src/lsu_subsys.sv
test/lsu_subsys_checker.sv
test/tb_lsu_subsys.sv

// File: src/ctl_pkg.sv
// Access controller types
`default_nettype none

package ctl_pkg;

  // one command at a time, no overlap
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,  // waiting for req
    ST_ACCESS = 2'd1,  // bus valid held
    ST_DONE   = 2'd2   // single cycle done
  } lsu_state_e;

endpackage : ctl_pkg

`default_nettype wire

// File: src/data_ram.sv
// Byte lane data memory
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
  parameter int unsigned XLEN      = 32,
  parameter int unsigned AW        = 12,
  parameter int unsigned MEM_WORDS = 1024  // power of two
) (
  input  wire logic              clk,
  input  wire logic              ls_vld,
  input  wire logic              ls_rdy,
  input  wire logic              ls_wen,
  input  wire logic [AW-1:0]     ls_adr,  // byte address, word aligned
  input  wire logic [XLEN/8-1:0] ls_ben,
  input  wire logic [XLEN-1:0]   ls_wdt,
  output logic      [XLEN-1:0]   ls_rdt   // held between reads
);

  localparam int unsigned BW = XLEN/8;
  localparam int unsigned WW = $clog2(BW);
  localparam int unsigned IW = $clog2(MEM_WORDS);

  logic [XLEN-1:0] mem [MEM_WORDS];  // no init, undefined until written
  logic [IW-1:0]   idx;
  logic            trn;

  // word index wraps at MEM_WORDS
  assign idx = IW'(ls_adr >> WW);
  assign trn = ls_vld & ls_rdy;

  ////////////////////////////////////////////////////////////////////////////
  // write and read ports
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (trn && ls_wen) begin
      for (int b = 0; b < BW; b++) begin
        if (ls_ben[b]) mem[idx][8*b +: 8] <= ls_wdt[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (trn && !ls_wen) ls_rdt <= mem[idx];  // registered at the transfer
  end

endmodule : data_ram

`default_nettype wire

// File: src/isa_pkg.sv
// RV32 load/store encodings
`default_nettype none

package isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // major opcode, inst[6:0]
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    LOAD  = 7'b0000011,  // I-type loads
    STORE = 7'b0100011   // S-type stores
  } opc_e;

  ////////////////////////////////////////////////////////////////////////////
  // funct3 width codes, inst[14:12]
  ////////////////////////////////////////////////////////////////////////////

  // load widths, bit 2 selects zero extension
  typedef enum logic [2:0] {
    LB  = 3'b000,  // byte, signed
    LH  = 3'b001,  // half, signed
    LW  = 3'b010,  // word
    LBU = 3'b100,  // byte, unsigned
    LHU = 3'b101   // half, unsigned
  } ld_f3_e;

  // store widths share the low two bits with loads
  typedef enum logic [2:0] {
    SB = 3'b000,  // byte
    SH = 3'b001,  // half
    SW = 3'b010   // word
  } st_f3_e;

endpackage : isa_pkg

`default_nettype wire

// File: src/lsu_align.sv
// Load/store lane alignment
`timescale 1ns/100ps
`default_nettype none

module lsu_align #(
  parameter int unsigned XLEN = 32,  // data width of 32 only
  parameter int unsigned AW   = 12   // byte address width
) (
  input  wire logic            clk,
  input  wire logic            rst,
  // command
  input  wire logic            cap,      // capture strobe from ctrl
  input  wire isa_pkg::opc_e   opc,
  input  wire logic [2:0]      fn3,      // load or store code per opc
  input  wire logic [AW-1:0]   adr,      // byte address
  input  wire logic [XLEN-1:0] wdt,      // store data
  output logic                 mal_now,  // misalignment of command at cap
  output logic [XLEN-1:0]      rdt,      // extended load data
  // word bus
  input  wire logic            ls_vld,
  input  wire logic            ls_rdy,
  input  wire logic [XLEN-1:0] ls_rdt,
  output logic                 ls_wen,
  output logic [AW-1:0]        ls_adr,
  output logic [XLEN/8-1:0]    ls_ben,
  output logic [XLEN-1:0]      ls_wdt
);

  localparam int unsigned BW = XLEN/8;      // byte lanes
  localparam int unsigned WW = $clog2(BW);  // lane select bits

  isa_pkg::opc_e    opc_q;
  logic [2:0]       fn3_q;
  logic [AW-1:0]    adr_q;
  logic [XLEN-1:0]  wdt_q;
  logic             ls_rtr;  // read transfer
  logic [WW-1:0]    ral;     // read lane offset
  isa_pkg::ld_f3_e  rf3;     // read width code

  ////////////////////////////////////////////////////////////////////////////
  // command register and misalignment
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      opc_q <= isa_pkg::LOAD;
      fn3_q <= 3'b010;
    end else if (cap) begin
      opc_q <= opc;
      fn3_q <= fn3;
    end
  end

  always_ff @(posedge clk) begin
    if (cap) begin
      adr_q <= adr;  // address and data payload
      wdt_q <= wdt;
    end
  end

  // decoded from the live fields so the ctrl can skip the bus at capture;
  // loads and stores use the same width rule
  always_comb begin
    mal_now = 1'b0;
    case (fn3[1:0])
      2'b01:   mal_now = adr[0];       // half
      2'b10:   mal_now = |adr[1:0];    // word
      default: mal_now = 1'b0;         // byte never misaligned
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus request side
  ////////////////////////////////////////////////////////////////////////////

  assign ls_wen = (opc_q == isa_pkg::STORE);
  assign ls_adr = {adr_q[AW-1:WW], WW'(0)};  // word aligned

  // stores enable only their lanes, loads fetch the whole word
  always_comb begin
    if (opc_q == isa_pkg::STORE) begin
      case (isa_pkg::st_f3_e'(fn3_q))
        isa_pkg::SB: ls_ben = BW'(4'b0001 << adr_q[WW-1:0]);
        isa_pkg::SH: ls_ben = BW'(4'b0011 << adr_q[WW-1:0]);
        default:     ls_ben = '1;
      endcase
    end else begin
      ls_ben = '1;
    end
  end

  // replicate the store value so every enabled lane sees it
  always_comb begin
    case (isa_pkg::st_f3_e'(fn3_q))
      isa_pkg::SB: ls_wdt = {BW{wdt_q[7:0]}};
      isa_pkg::SH: ls_wdt = {(BW/2){wdt_q[15:0]}};
      default:     ls_wdt = wdt_q;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // load return path
  ////////////////////////////////////////////////////////////////////////////

  assign ls_rtr = ls_vld & ls_rdy & ~ls_wen;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ral <= '0;
      rf3 <= isa_pkg::LW;
    end else if (ls_rtr) begin
      ral <= adr_q[WW-1:0];
      rf3 <= isa_pkg::ld_f3_e'(fn3_q);
    end
  end

  always_comb begin : blk_rdt
    logic [XLEN-1:0] tmp;
    tmp = ls_rdt >> (8*ral);  // addressed lane down to bit 0
    case (rf3)
      isa_pkg::LB:  rdt = {{(XLEN-8){tmp[7]}}, tmp[7:0]};
      isa_pkg::LH:  rdt = {{(XLEN-16){tmp[15]}}, tmp[15:0]};
      isa_pkg::LBU: rdt = {{(XLEN-8){1'b0}}, tmp[7:0]};
      isa_pkg::LHU: rdt = {{(XLEN-16){1'b0}}, tmp[15:0]};
      default:      rdt = tmp;  // LW
    endcase
  end : blk_rdt

endmodule : lsu_align

`default_nettype wire

// File: src/lsu_ctrl.sv
// Load/store access controller
`timescale 1ns/100ps
`default_nettype none

module lsu_ctrl (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic req,      // command strobe
  input  wire logic mal_now,  // misalignment of presented command
  input  wire logic ls_rdy,   // bus ready pulse
  output logic      cap,      // capture strobe to aligner
  output logic      ls_vld,   // bus valid level
  output logic      done,     // one cycle completion
  output logic      mal,      // misaligned flag, held until next command
  output logic      busy
);

  ctl_pkg::lsu_state_e state_q;
  ctl_pkg::lsu_state_e state_d;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  // req only looked at in idle, anything else is dropped
  assign cap = (state_q == ctl_pkg::ST_IDLE) & req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctl_pkg::ST_IDLE: begin
        if (req) begin
          // misaligned skips the bus entirely
          state_d = mal_now ? ctl_pkg::ST_DONE : ctl_pkg::ST_ACCESS;
        end
      end
      ctl_pkg::ST_ACCESS: begin
        if (ls_rdy) state_d = ctl_pkg::ST_DONE;  // transfer this edge
      end
      ctl_pkg::ST_DONE: state_d = ctl_pkg::ST_IDLE;
      default:          state_d = ctl_pkg::ST_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and flag registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q <= ctl_pkg::ST_IDLE;
      mal     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (cap) mal <= mal_now;  // refreshed per command
    end
  end

  // outputs straight from state
  assign ls_vld = (state_q == ctl_pkg::ST_ACCESS);
  assign done   = (state_q == ctl_pkg::ST_DONE);
  assign busy   = (state_q != ctl_pkg::ST_IDLE);  // drops with done

endmodule : lsu_ctrl

`default_nettype wire

// File: src/lsu_subsys.sv
// Load/store subsystem top
`timescale 1ns/100ps
`default_nettype none

module lsu_subsys #(
  parameter int unsigned XLEN        = 32,
  parameter int unsigned AW          = 12,
  parameter int unsigned MEM_WORDS   = 1024,
  parameter int unsigned WAIT_CYCLES = 2
) (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            req,
  input  wire isa_pkg::opc_e   opc,
  input  wire logic [2:0]      fn3,
  input  wire logic [AW-1:0]   adr,
  input  wire logic [XLEN-1:0] wdt,
  output logic      [XLEN-1:0] rdt,
  output logic                 mal,
  output logic                 done,
  output logic                 busy
);

  logic              cap;
  logic              mal_now;
  // internal word bus
  logic              ls_vld;
  logic              ls_rdy;
  logic              ls_wen;
  logic [AW-1:0]     ls_adr;
  logic [XLEN/8-1:0] ls_ben;
  logic [XLEN-1:0]   ls_wdt;
  logic [XLEN-1:0]   ls_rdt;

  lsu_ctrl ctrl_inst (
    .clk, .rst, .req, .mal_now, .ls_rdy,
    .cap, .ls_vld, .done, .mal, .busy
  );

  wait_timer #(.WAIT_CYCLES(WAIT_CYCLES)) timer_inst (
    .clk, .rst, .ls_vld, .ls_rdy
  );

  lsu_align #(.XLEN(XLEN), .AW(AW)) align_inst (
    .clk, .rst, .cap, .opc, .fn3, .adr, .wdt, .mal_now, .rdt,
    .ls_vld, .ls_rdy, .ls_rdt, .ls_wen, .ls_adr, .ls_ben, .ls_wdt
  );

  data_ram #(.XLEN(XLEN), .AW(AW), .MEM_WORDS(MEM_WORDS)) ram_inst (
    .clk, .ls_vld, .ls_rdy, .ls_wen, .ls_adr, .ls_ben, .ls_wdt, .ls_rdt
  );

endmodule : lsu_subsys

`default_nettype wire

// File: src/wait_timer.sv
// Bus wait state timer
`timescale 1ns/100ps
`default_nettype none

module wait_timer #(
  parameter int unsigned WAIT_CYCLES = 2  // 0 to 7
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic ls_vld,  // request level
  output logic      ls_rdy   // single cycle acknowledge
);

  // one extra count past the target so ready cannot repeat
  localparam int unsigned CW = $clog2(WAIT_CYCLES + 2);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else if (!ls_vld) begin
      cnt <= '0;                         // idle bus restarts the wait
    end else if (cnt <= CW'(WAIT_CYCLES)) begin
      cnt <= cnt + 1'b1;                 // parks at WAIT_CYCLES+1
    end
  end

  // zero waits gives ready in the first valid cycle
  assign ls_rdy = ls_vld & (cnt == CW'(WAIT_CYCLES));

endmodule : wait_timer

`default_nettype wire

// File: test/lsu_subsys_checker.sv
// LSU controller protocol checker
`timescale 1ns/100ps
`default_nettype none

module lsu_subsys_checker (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                cap,
  input  wire logic                ls_vld,
  input  wire logic                done,
  input  wire logic                mal,
  input  wire logic                busy,
  input  wire ctl_pkg::lsu_state_e state_q  // controller state register
);

  // capture goes to the bus or straight to done by the registered flag
  cap_routes: assert property (@(posedge clk) disable iff (rst)
    cap |=> state_q == (mal ? ctl_pkg::ST_DONE : ctl_pkg::ST_ACCESS))
    else $error("state after capture does not follow mal");

  done_one_cycle: assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else $error("done held for more than one cycle");

  // misaligned commands never reach the bus
  vld_not_mal: assert property (@(posedge clk) disable iff (rst)
    $rose(ls_vld) |-> !mal)
    else $error("ls_vld raised for a misaligned command");

  // busy only drops at the edge that ends done
  busy_until_done: assert property (@(posedge clk) disable iff (rst)
    $fell(busy) |-> $past(done))
    else $error("busy fell without a done cycle");

endmodule : lsu_subsys_checker

bind lsu_ctrl lsu_subsys_checker chk_inst (
  .clk, .rst, .cap, .ls_vld, .done, .mal, .busy, .state_q
);

`default_nettype wire

// File: test/lsu_tests.txt
// opc_fn3_adr_wdt_rdt_mal, rdt checked on aligned loads only
23_2_100_12345678_00000000_0
03_2_100_00000000_12345678_0
23_0_101_000000ab_00000000_0
23_0_103_555555f0_00000000_0
23_1_102_aaaa8001_00000000_0
03_2_100_00000000_8001ab78_0
23_0_102_ffffffc3_00000000_0
23_0_100_0000009e_00000000_0
03_2_100_00000000_80c3ab9e_0
23_1_100_12347fee_00000000_0
03_2_100_00000000_80c37fee_0
03_0_100_00000000_ffffffee_0
03_0_101_00000000_0000007f_0
03_0_102_00000000_ffffffc3_0
03_0_103_00000000_ffffff80_0
03_4_100_00000000_000000ee_0
03_4_101_00000000_0000007f_0
03_4_102_00000000_000000c3_0
03_4_103_00000000_00000080_0
03_1_100_00000000_00007fee_0
03_1_102_00000000_ffff80c3_0
03_5_100_00000000_00007fee_0
03_5_102_00000000_000080c3_0
23_1_101_deadbeef_00000000_1
23_2_102_deadbeef_00000000_1
03_1_103_00000000_00000000_1
03_2_101_00000000_00000000_1
03_2_100_00000000_80c37fee_0

// File: test/tb_lsu_subsys.sv
// LSU subsystem testbench
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_subsys;

  localparam int unsigned XLEN        = 32;
  localparam int unsigned AW          = 12;
  localparam int unsigned MEM_WORDS   = 1024;
  localparam int unsigned WAIT_CYCLES = 2;
  localparam int          MAX_VEC     = 64;
  localparam int          TMO         = 40;  // cycles allowed per wait loop

  logic            clk;
  logic            rst;
  logic            req;
  isa_pkg::opc_e   opc;
  logic [2:0]      fn3;
  logic [AW-1:0]   adr;
  logic [XLEN-1:0] wdt;
  logic [XLEN-1:0] rdt;
  logic            mal;
  logic            done;
  logic            busy;

  logic [91:0]     vecs [MAX_VEC];  // opc 8, fn3 4, adr 12, wdt 32, rdt 32, mal 4
  logic [XLEN-1:0] ref_mem [int];   // reference words by word index
  int unsigned     lcg_state = 71;
  int              n_cmd;
  int              n_done;
  int              err_val;
  int              err_other;
  logic            tmo_hit;         // a done wait ran out

  lsu_subsys #(
    .XLEN(XLEN), .AW(AW), .MEM_WORDS(MEM_WORDS), .WAIT_CYCLES(WAIT_CYCLES)
  ) lsu_subsys_inst (
    .clk, .rst, .req, .opc, .fn3, .adr, .wdt, .rdt, .mal, .done, .busy
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // counts done cycles so a stray capture shows up as an extra one
  always @(negedge clk) begin
    if (!rst && done) n_done++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // upper bits since the low ones cycle fast
  endfunction

  // width mask of 1, 2 or 4 bytes starting at the addressed lane
  task automatic apply_store(input logic [2:0] f3, input logic [AW-1:0] a,
                             input logic [XLEN-1:0] d);
    int              idx;
    int              off;
    int              nb;
    logic [XLEN-1:0] word;
    idx  = int'(a[AW-1:2]);
    off  = int'(a[1:0]);
    nb   = 1 << f3[1:0];  // bytes written
    word = ref_mem.exists(idx) ? ref_mem[idx] : '0;
    for (int b = off; b < off + nb; b++) begin
      word[8*b +: 8] = d[8*(b-off) +: 8];  // data low bytes go up from the lane
    end
    ref_mem[idx] = word;
  endtask

  function automatic logic [XLEN-1:0] expect_load(input logic [2:0] f3,
                                                  input logic [AW-1:0] a);
    logic [XLEN-1:0] val;
    int              nbit;
    val  = ref_mem[int'(a[AW-1:2])] >> (8 * int'(a[1:0]));
    nbit = 8 << f3[1:0];
    for (int i = nbit; i < XLEN; i++) begin
      val[i] = f3[2] ? 1'b0 : val[nbit-1];  // bit 2 unsigned
    end
    return val;
  endfunction

  task automatic print_counts();
    $display("commands %0d, done pulses %0d, value errors %0d, other errors %0d",
             n_cmd, n_done, err_val, err_other);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one command from request through done back to idle
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_cmd(input logic [91:0] v);
    logic [XLEN-1:0] exp_rdt;
    logic [XLEN-1:0] mdl;
    logic            exp_mal;
    logic            is_ld;
    int              lat;
    int              exp_lat;
    logic            seen;
    exp_rdt = v[35:4];
    exp_mal = v[0];
    is_ld   = (v[90:84] == isa_pkg::LOAD);
    exp_lat = exp_mal ? 1 : int'(WAIT_CYCLES) + 2;
    repeat (next_rand() % 4) @(posedge clk);  // idle gap
    @(posedge clk);
    req <= 1'b1;
    opc <= isa_pkg::opc_e'(v[90:84]);
    fn3 <= v[82:80];
    adr <= v[79:68];
    wdt <= v[67:36];
    @(posedge clk);  // req sampled here
    req   <= 1'b0;
    n_cmd++;
    lat   = 0;
    seen  = 1'b0;
    while (!seen && lat < TMO) begin
      @(negedge clk);
      lat++;
      if (done) begin
        seen = 1'b1;
      end else begin
        assert (busy) else begin
          $display("[FAIL] t=%0t busy expected 1 got %b", $time, busy);
          err_val++;
        end
        @(posedge clk);
        req <= (lat == 1) && !exp_mal;  // stray req while busy
      end
    end
    if (!seen) begin
      $display("ERROR: no done pulse within %0d cycles of command %0d", TMO, n_cmd);
      err_other++;
      tmo_hit = 1'b1;
    end else begin
      assert (lat == exp_lat) else begin
        $display("[FAIL] t=%0t done latency expected %0d got %0d", $time, exp_lat, lat);
        err_val++;
      end
      assert (mal === exp_mal) else begin
        $display("[FAIL] t=%0t mal expected %b got %b", $time, exp_mal, mal);
        err_val++;
      end
      if (is_ld && !exp_mal) begin
        mdl = expect_load(v[82:80], v[79:68]);
        assert (rdt === exp_rdt) else begin
          $display("[FAIL] t=%0t rdt expected %h got %h", $time, exp_rdt, rdt);
          err_val++;
        end
        assert (rdt === mdl) else begin
          $display("[FAIL] t=%0t rdt expected %h got %h (model)", $time, mdl, rdt);
          err_val++;
        end
      end else if (!exp_mal) begin
        apply_store(v[82:80], v[79:68], v[67:36]);
      end
      @(posedge clk);  // edge ending done
      req <= 1'b0;
      @(negedge clk);
      assert (!busy) else begin
        $display("[FAIL] t=%0t busy expected 0 got %b", $time, busy);
        err_val++;
      end
      assert (!done) else begin
        $display("[FAIL] t=%0t done expected 0 got %b", $time, done);
        err_val++;
      end
    end
  endtask

  initial begin
    int i;
    rst       = 1'b1;
    req       = 1'b0;
    opc       = isa_pkg::LOAD;
    fn3       = 3'b000;
    adr       = '0;
    wdt       = '0;
    n_cmd     = 0;
    n_done    = 0;
    err_val   = 0;
    err_other = 0;
    tmo_hit   = 1'b0;
    for (i = 0; i < MAX_VEC; i++) vecs[i] = '1;  // all ones marks the end
    $readmemh("test/lsu_tests.txt", vecs);
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    i = 0;
    while (i < MAX_VEC && vecs[i][91:84] != 8'hff && !tmo_hit) begin
      run_cmd(vecs[i]);
      i++;
    end
    repeat (4) @(posedge clk);
    assert (n_cmd > 0 && n_done == n_cmd) else begin
      $display("ERROR: %0d done pulses seen for %0d commands", n_done, n_cmd);
      err_other++;
    end
    print_counts();
    if (err_val + err_other == 0) $display("Simulation passed");
    else $display("Simulation failed");
    $finish;
  end

endmodule : tb_lsu_subsys

`default_nettype wire
